/* verilog/mmap_pkg.sv */
package mmap_pkg;

  // decode result of the shared bus address
  typedef enum logic [1:0] {
    REGION_SRAM  = 2'd0,
    REGION_GPIO  = 2'd1,
    REGION_TIMER = 2'd2,
    REGION_NONE  = 2'd3
  } region_e;

  // region bases
  localparam logic [31:0] SRAM_BASE  = 32'h0000_0000;
  localparam logic [31:0] GPIO_BASE  = 32'h1000_0000;
  localparam logic [31:0] TIMER_BASE = 32'h1000_1000;

  // peripherals sit in 4 KB pages, sram is picked by addr[31:28]
  localparam logic [31:0] REGION_MASK = 32'hffff_f000;

  // gpio register offsets
  localparam logic [11:0] GPIO_OUT_OFS = 12'h000;
  localparam logic [11:0] GPIO_OEN_OFS = 12'h004;
  localparam logic [11:0] GPIO_IN_OFS  = 12'h008;

  // timer register offsets
  localparam logic [11:0] TMR_CTRL_OFS = 12'h000;
  localparam logic [11:0] TMR_CMP_OFS  = 12'h004;
  localparam logic [11:0] TMR_CNT_OFS  = 12'h008;
  localparam logic [11:0] TMR_STAT_OFS = 12'h00c;

  localparam logic [31:0] UNMAPPED_RDATA = 32'h0;

  // replace only the bytes enabled by the write strobe
  function automatic logic [31:0] strb_merge(input logic [31:0] old_word,
                                             input logic [31:0] new_word,
                                             input logic [3:0]  strb);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b+:8] = new_word[8*b+:8];
    end
    return res;
  endfunction

endpackage

/* verilog/bus_arbiter.sv */
module bus_arbiter (
  input  logic        clk_i,
  input  logic        rst_n_i,
  // core master
  input  logic        core_valid_i,
  input  logic [31:0] core_addr_i,
  input  logic [31:0] core_wdata_i,
  input  logic [ 3:0] core_wstrb_i,
  output logic        core_ready_o,
  output logic [31:0] core_rdata_o,
  // loader master
  input  logic        ldr_valid_i,
  input  logic [31:0] ldr_addr_i,
  input  logic [31:0] ldr_wdata_i,
  input  logic [ 3:0] ldr_wstrb_i,
  output logic        ldr_ready_o,
  output logic [31:0] ldr_rdata_o,
  // shared bus
  output logic        bus_valid_o,
  output logic [31:0] bus_addr_o,
  output logic [31:0] bus_wdata_o,
  output logic [ 3:0] bus_wstrb_o,
  input  logic        bus_ready_i,
  input  logic [31:0] bus_rdata_i
);
  localparam logic [1:0] GNT_IDLE = 2'd0;
  localparam logic [1:0] GNT_CORE = 2'd1;
  localparam logic [1:0] GNT_LDR  = 2'd2;

  logic [1:0] gnt_q;
  // set while the loader had the last grant, so the core wins the first tie
  logic       last_ldr_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gnt_q      <= GNT_IDLE;
      last_ldr_q <= 1'b1;
    end else begin
      case (gnt_q)
        GNT_IDLE: begin
          if (core_valid_i && (!ldr_valid_i || last_ldr_q)) begin
            gnt_q      <= GNT_CORE;
            last_ldr_q <= 1'b0;
          end else if (ldr_valid_i) begin
            gnt_q      <= GNT_LDR;
            last_ldr_q <= 1'b1;
          end
        end
        default: begin
          // release on the response, a waiting request is taken next cycle
          if (bus_ready_i) gnt_q <= GNT_IDLE;
        end
      endcase
    end
  end

  // steer the granted request onto the bus
  assign bus_valid_o = (gnt_q == GNT_CORE && core_valid_i) ||
                       (gnt_q == GNT_LDR && ldr_valid_i);
  assign bus_addr_o  = (gnt_q == GNT_LDR) ? ldr_addr_i : core_addr_i;
  assign bus_wdata_o = (gnt_q == GNT_LDR) ? ldr_wdata_i : core_wdata_i;
  assign bus_wstrb_o = (gnt_q == GNT_LDR) ? ldr_wstrb_i : core_wstrb_i;

  // response goes back only to the owner
  assign core_ready_o = (gnt_q == GNT_CORE) && bus_ready_i;
  assign core_rdata_o = (gnt_q == GNT_CORE) ? bus_rdata_i : 32'h0;
  assign ldr_ready_o  = (gnt_q == GNT_LDR) && bus_ready_i;
  assign ldr_rdata_o  = (gnt_q == GNT_LDR) ? bus_rdata_i : 32'h0;

endmodule

/* verilog/bus_decoder.sv */
module bus_decoder
  import mmap_pkg::*;
#(
  parameter int SRAM_WORDS = 256
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        bus_valid_i,
  input  logic [31:0] bus_addr_i,
  input  logic [31:0] bus_wdata_i,
  input  logic [ 3:0] bus_wstrb_i,
  output logic        bus_ready_o,
  output logic [31:0] bus_rdata_o,
  output logic        sram_valid_o,
  output logic        gpio_valid_o,
  output logic        tmr_valid_o,
  output logic [31:0] tgt_addr_o,
  output logic [31:0] tgt_wdata_o,
  output logic [ 3:0] tgt_wstrb_o,
  input  logic        sram_ready_i,
  input  logic [31:0] sram_rdata_i,
  input  logic        gpio_ready_i,
  input  logic [31:0] gpio_rdata_i,
  input  logic        tmr_ready_i,
  input  logic [31:0] tmr_rdata_i
);
  localparam logic [27:0] SRAM_BYTES = 28'(SRAM_WORDS * 4);

  region_e region;
  logic    issued_q;
  logic    strobe;
  logic    none_ready_q;

  // address classification
  always_comb begin
    if (bus_addr_i[31:28] == SRAM_BASE[31:28] && bus_addr_i[27:0] < SRAM_BYTES) begin
      region = REGION_SRAM;
    end else if ((bus_addr_i & REGION_MASK) == GPIO_BASE) begin
      region = REGION_GPIO;
    end else if ((bus_addr_i & REGION_MASK) == TIMER_BASE) begin
      region = REGION_TIMER;
    end else begin
      region = REGION_NONE;
    end
  end

  // one strobe per request while valid is held
  assign strobe = bus_valid_i && !issued_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      issued_q     <= 1'b0;
      none_ready_q <= 1'b0;
    end else begin
      if (bus_ready_o) issued_q <= 1'b0;
      else if (strobe) issued_q <= 1'b1;
      // unmapped responder, writes are dropped here
      none_ready_q <= strobe && (region == REGION_NONE);
    end
  end

  assign sram_valid_o = strobe && (region == REGION_SRAM);
  assign gpio_valid_o = strobe && (region == REGION_GPIO);
  assign tmr_valid_o  = strobe && (region == REGION_TIMER);

  assign tgt_addr_o  = bus_addr_i;
  assign tgt_wdata_o = bus_wdata_i;
  assign tgt_wstrb_o = bus_wstrb_i;

  assign bus_ready_o = sram_ready_i || gpio_ready_i || tmr_ready_i || none_ready_q;

  // return path follows whichever target answered
  always_comb begin
    if (sram_ready_i) bus_rdata_o = sram_rdata_i;
    else if (gpio_ready_i) bus_rdata_o = gpio_rdata_i;
    else if (tmr_ready_i) bus_rdata_o = tmr_rdata_i;
    else bus_rdata_o = UNMAPPED_RDATA;
  end

endmodule

/* verilog/sram_ctrl.sv */
module sram_ctrl
  import mmap_pkg::*;
#(
  parameter int SRAM_WORDS = 256
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        valid_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  input  logic [ 3:0] wstrb_i,
  output logic        ready_o,
  output logic [31:0] rdata_o
);
  localparam int AW = $clog2(SRAM_WORDS);

  logic [31:0]   mem [SRAM_WORDS];
  logic [AW-1:0] idx;
  logic          ready_q;
  logic [31:0]   rdata_q;

  // word index, base is region aligned
  assign idx = addr_i[AW+1:2];

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      if (wstrb_i != 4'b0) mem[idx] <= strb_merge(mem[idx], wdata_i, wstrb_i);
      rdata_q <= mem[idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= valid_i;
    end
  end

  assign ready_o = ready_q;
  assign rdata_o = rdata_q;

endmodule

/* verilog/gpio_regs.sv */
module gpio_regs
  import mmap_pkg::*;
#(
  parameter int GPIO_WIDTH = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  valid_i,
  input  logic [          31:0] addr_i,
  input  logic [          31:0] wdata_i,
  input  logic [           3:0] wstrb_i,
  output logic                  ready_o,
  output logic [          31:0] rdata_o,
  input  logic [GPIO_WIDTH-1:0] gpio_in_i,
  output logic [GPIO_WIDTH-1:0] gpio_out_o,
  output logic [GPIO_WIDTH-1:0] gpio_oen_o
);
  logic [GPIO_WIDTH-1:0] out_q;
  logic [GPIO_WIDTH-1:0] oen_q;
  logic [GPIO_WIDTH-1:0] in_meta_q;
  logic [GPIO_WIDTH-1:0] in_sync_q;
  logic                  ready_q;
  logic [          31:0] rdata_q;
  logic                  wr;
  logic [          11:0] ofs;

  assign wr  = valid_i && (wstrb_i != 4'b0);
  assign ofs = addr_i[11:0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_q   <= '0;
      oen_q   <= '0;
      ready_q <= 1'b0;
    end else begin
      ready_q <= valid_i;
      if (wr && ofs == GPIO_OUT_OFS) out_q <= GPIO_WIDTH'(strb_merge(32'(out_q), wdata_i, wstrb_i));
      if (wr && ofs == GPIO_OEN_OFS) oen_q <= GPIO_WIDTH'(strb_merge(32'(oen_q), wdata_i, wstrb_i));
    end
  end

  // two-flop synchronizer on the pins
  always_ff @(posedge clk_i) begin
    in_meta_q <= gpio_in_i;
    in_sync_q <= in_meta_q;
  end

  // input offset is read only
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      case (ofs)
        GPIO_OUT_OFS: rdata_q <= 32'(out_q);
        GPIO_OEN_OFS: rdata_q <= 32'(oen_q);
        GPIO_IN_OFS:  rdata_q <= 32'(in_sync_q);
        default:      rdata_q <= 32'h0;
      endcase
    end
  end

  assign ready_o    = ready_q;
  assign rdata_o    = rdata_q;
  assign gpio_out_o = out_q;
  assign gpio_oen_o = oen_q;

endmodule

/* verilog/timer_irq.sv */
module timer_irq
  import mmap_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        valid_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] wdata_i,
  input  logic [ 3:0] wstrb_i,
  output logic        ready_o,
  output logic [31:0] rdata_o,
  output logic        irq_o
);
  logic        en_q;
  logic [31:0] cmp_q;
  logic [31:0] cnt_q;
  logic        stat_q;
  logic        ready_q;
  logic [31:0] rdata_q;
  logic        wr;
  logic [11:0] ofs;
  logic        match;

  assign wr    = valid_i && (wstrb_i != 4'b0);
  assign ofs   = addr_i[11:0];
  assign match = en_q && (cnt_q == cmp_q);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q    <= 1'b0;
      cmp_q   <= 32'h0;
      cnt_q   <= 32'h0;
      stat_q  <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      ready_q <= valid_i;
      // any control write restarts the count
      if (wr && ofs == TMR_CTRL_OFS) begin
        if (wstrb_i[0]) en_q <= wdata_i[0];
        cnt_q <= 32'h0;
      end else if (en_q) begin
        cnt_q <= cnt_q + 32'd1;
      end
      if (wr && ofs == TMR_CMP_OFS) cmp_q <= strb_merge(cmp_q, wdata_i, wstrb_i);
      // a match in the same cycle as the clear still wins
      if (match) begin
        stat_q <= 1'b1;
      end else if (wr && ofs == TMR_STAT_OFS && wstrb_i[0] && wdata_i[0]) begin
        stat_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      case (ofs)
        TMR_CTRL_OFS: rdata_q <= {31'h0, en_q};
        TMR_CMP_OFS:  rdata_q <= cmp_q;
        TMR_CNT_OFS:  rdata_q <= cnt_q;
        TMR_STAT_OFS: rdata_q <= {31'h0, stat_q};
        default:      rdata_q <= 32'h0;
      endcase
    end
  end

  assign ready_o = ready_q;
  assign rdata_o = rdata_q;
  assign irq_o   = stat_q;

endmodule

/* verilog/retrosoc_lite.sv */
module retrosoc_lite #(
  parameter int SRAM_WORDS = 256,
  parameter int GPIO_WIDTH = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // core master port
  input  logic                  core_valid_i,
  input  logic [          31:0] core_addr_i,
  input  logic [          31:0] core_wdata_i,
  input  logic [           3:0] core_wstrb_i,
  output logic                  core_ready_o,
  output logic [          31:0] core_rdata_o,
  // loader master port
  input  logic                  ldr_valid_i,
  input  logic [          31:0] ldr_addr_i,
  input  logic [          31:0] ldr_wdata_i,
  input  logic [           3:0] ldr_wstrb_i,
  output logic                  ldr_ready_o,
  output logic [          31:0] ldr_rdata_o,
  // pins
  input  logic [GPIO_WIDTH-1:0] gpio_in_i,
  output logic [GPIO_WIDTH-1:0] gpio_out_o,
  output logic [GPIO_WIDTH-1:0] gpio_oen_o,
  output logic                  irq_o
);
  // shared bus after arbitration
  logic        bus_valid;
  logic [31:0] bus_addr;
  logic [31:0] bus_wdata;
  logic [ 3:0] bus_wstrb;
  logic        bus_ready;
  logic [31:0] bus_rdata;
  // target side
  logic        sram_valid;
  logic        gpio_valid;
  logic        tmr_valid;
  logic [31:0] tgt_addr;
  logic [31:0] tgt_wdata;
  logic [ 3:0] tgt_wstrb;
  logic        sram_ready;
  logic [31:0] sram_rdata;
  logic        gpio_ready;
  logic [31:0] gpio_rdata;
  logic        tmr_ready;
  logic [31:0] tmr_rdata;

  bus_arbiter u_bus_arbiter (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .core_valid_i(core_valid_i),
    .core_addr_i (core_addr_i),
    .core_wdata_i(core_wdata_i),
    .core_wstrb_i(core_wstrb_i),
    .core_ready_o(core_ready_o),
    .core_rdata_o(core_rdata_o),
    .ldr_valid_i (ldr_valid_i),
    .ldr_addr_i  (ldr_addr_i),
    .ldr_wdata_i (ldr_wdata_i),
    .ldr_wstrb_i (ldr_wstrb_i),
    .ldr_ready_o (ldr_ready_o),
    .ldr_rdata_o (ldr_rdata_o),
    .bus_valid_o (bus_valid),
    .bus_addr_o  (bus_addr),
    .bus_wdata_o (bus_wdata),
    .bus_wstrb_o (bus_wstrb),
    .bus_ready_i (bus_ready),
    .bus_rdata_i (bus_rdata)
  );

  bus_decoder #(
    .SRAM_WORDS(SRAM_WORDS)
  ) u_bus_decoder (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .bus_valid_i (bus_valid),
    .bus_addr_i  (bus_addr),
    .bus_wdata_i (bus_wdata),
    .bus_wstrb_i (bus_wstrb),
    .bus_ready_o (bus_ready),
    .bus_rdata_o (bus_rdata),
    .sram_valid_o(sram_valid),
    .gpio_valid_o(gpio_valid),
    .tmr_valid_o (tmr_valid),
    .tgt_addr_o  (tgt_addr),
    .tgt_wdata_o (tgt_wdata),
    .tgt_wstrb_o (tgt_wstrb),
    .sram_ready_i(sram_ready),
    .sram_rdata_i(sram_rdata),
    .gpio_ready_i(gpio_ready),
    .gpio_rdata_i(gpio_rdata),
    .tmr_ready_i (tmr_ready),
    .tmr_rdata_i (tmr_rdata)
  );

  sram_ctrl #(
    .SRAM_WORDS(SRAM_WORDS)
  ) u_sram_ctrl (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(sram_valid),
    .addr_i (tgt_addr),
    .wdata_i(tgt_wdata),
    .wstrb_i(tgt_wstrb),
    .ready_o(sram_ready),
    .rdata_o(sram_rdata)
  );

  gpio_regs #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) u_gpio_regs (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .valid_i   (gpio_valid),
    .addr_i    (tgt_addr),
    .wdata_i   (tgt_wdata),
    .wstrb_i   (tgt_wstrb),
    .ready_o   (gpio_ready),
    .rdata_o   (gpio_rdata),
    .gpio_in_i (gpio_in_i),
    .gpio_out_o(gpio_out_o),
    .gpio_oen_o(gpio_oen_o)
  );

  timer_irq u_timer_irq (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(tmr_valid),
    .addr_i (tgt_addr),
    .wdata_i(tgt_wdata),
    .wstrb_i(tgt_wstrb),
    .ready_o(tmr_ready),
    .rdata_o(tmr_rdata),
    .irq_o  (irq_o)
  );

endmodule

/* testbench/tb_retrosoc_lite.sv */
module tb_retrosoc_lite
  import mmap_pkg::*;
();
  localparam int SRAM_WORDS   = 256;
  localparam int GPIO_WIDTH   = 8;
  localparam int NUM_TESTS    = 6;
  localparam int CLK_PERIOD   = 40;
  localparam int ACCESS_LIMIT = 100;
  localparam int PORT_CORE    = 0;
  localparam int PORT_LDR     = 1;

  logic                  clk;
  logic                  rst_n;
  logic                  core_valid;
  logic [          31:0] core_addr;
  logic [          31:0] core_wdata;
  logic [           3:0] core_wstrb;
  logic                  core_ready;
  logic [          31:0] core_rdata;
  logic                  ldr_valid;
  logic [          31:0] ldr_addr;
  logic [          31:0] ldr_wdata;
  logic [           3:0] ldr_wstrb;
  logic                  ldr_ready;
  logic [          31:0] ldr_rdata;
  logic [GPIO_WIDTH-1:0] gpio_in;
  logic [GPIO_WIDTH-1:0] gpio_out;
  logic [GPIO_WIDTH-1:0] gpio_oen;
  logic                  irq;

  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          test_err_start;
  string       cur_test;
  logic [31:0] rng_state;
  // master that finished its access last
  int          last_port;
  time         done_time [2];
  logic [31:0] model_mem [16];

  retrosoc_lite #(
    .SRAM_WORDS(SRAM_WORDS),
    .GPIO_WIDTH(GPIO_WIDTH)
  ) uut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .core_valid_i(core_valid),
    .core_addr_i (core_addr),
    .core_wdata_i(core_wdata),
    .core_wstrb_i(core_wstrb),
    .core_ready_o(core_ready),
    .core_rdata_o(core_rdata),
    .ldr_valid_i (ldr_valid),
    .ldr_addr_i  (ldr_addr),
    .ldr_wdata_i (ldr_wdata),
    .ldr_wstrb_i (ldr_wstrb),
    .ldr_ready_o (ldr_ready),
    .ldr_rdata_o (ldr_rdata),
    .gpio_in_i   (gpio_in),
    .gpio_out_o  (gpio_out),
    .gpio_oen_o  (gpio_oen),
    .irq_o       (irq)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // expected word after a strobed write
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] data,
                                              input logic [3:0]  strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (data & mask);
  endfunction

  function automatic logic [31:0] sram_addr(input int word);
    return SRAM_BASE + (32'(word) << 2);
  endfunction

  task automatic check_word(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("ERR t=%0t %s expected %h got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_gpio(input string name, input logic [GPIO_WIDTH-1:0] expected,
                            input logic [GPIO_WIDTH-1:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("ERR t=%0t %s expected %h got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      $display("ERR t=%0t %s expected %b got %b", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic drive_request(input int port, input logic v, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] wstrb);
    if (port == PORT_CORE) begin
      core_valid <= v;
      core_addr  <= addr;
      core_wdata <= wdata;
      core_wstrb <= wstrb;
    end else begin
      ldr_valid <= v;
      ldr_addr  <= addr;
      ldr_wdata <= wdata;
      ldr_wstrb <= wstrb;
    end
  endtask

  // one native bus access
  // lat counts cycles from valid to ready
  task automatic bus_access(input int port, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata,
                            output int lat);
    logic seen;
    lat   = 0;
    rdata = 32'h0;
    @(posedge clk);
    drive_request(port, 1'b1, addr, wdata, wstrb);
    @(negedge clk);
    seen = (port == PORT_CORE) ? core_ready : ldr_ready;
    while (!seen && lat < ACCESS_LIMIT) begin
      @(negedge clk);
      lat++;
      seen = (port == PORT_CORE) ? core_ready : ldr_ready;
    end
    if (!seen) begin
      $display("no ready on the %s port for address %h after %0d cycles",
               (port == PORT_CORE) ? "core" : "loader", addr, lat);
      errors++;
    end else begin
      rdata           = (port == PORT_CORE) ? core_rdata : ldr_rdata;
      done_time[port] = $time;
      last_port       = port;
    end
    @(posedge clk);
    drive_request(port, 1'b0, 32'h0, 32'h0, 4'h0);
  endtask

  task automatic bus_write(input int port, input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [31:0] rd_ignored;
    int          lat_ignored;
    bus_access(port, addr, data, strb, rd_ignored, lat_ignored);
  endtask

  task automatic bus_read(input int port, input logic [31:0] addr, output logic [31:0] data);
    int lat_ignored;
    bus_access(port, addr, 32'h0, 4'h0, data, lat_ignored);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    // the core wins the first tie after reset
    last_port = PORT_LDR;
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = errors;
    tests_run++;
  endtask

  task automatic end_test();
    if (errors == test_err_start) begin
      $display("test %s passed", cur_test);
    end else begin
      $display("test %s failed with %0d errors", cur_test, errors - test_err_start);
      tests_failed++;
    end
  endtask

  task automatic sram_access();
    logic [31:0] rd;
    logic [31:0] wd;
    logic [ 3:0] strb;
    start_test("sram");
    for (int i = 0; i < 16; i++) begin
      model_mem[i] = next_random();
      bus_write(PORT_CORE, sram_addr(i), model_mem[i], 4'hf);
    end
    for (int i = 0; i < 16; i++) begin
      bus_read(PORT_CORE, sram_addr(i), rd);
      check_word("core_rdata_o", model_mem[i], rd);
    end
    // byte lanes on the first four words
    for (int i = 0; i < 4; i++) begin
      strb         = 4'(3 * i + 1);
      wd           = next_random();
      model_mem[i] = merge_bytes(model_mem[i], wd, strb);
      bus_write(PORT_CORE, sram_addr(i), wd, strb);
    end
    for (int i = 0; i < 4; i++) begin
      bus_read(PORT_CORE, sram_addr(i), rd);
      check_word("core_rdata_o", model_mem[i], rd);
    end
    // one past the end would alias word 0 if the write got through
    bus_write(PORT_CORE, sram_addr(SRAM_WORDS), next_random(), 4'hf);
    bus_read(PORT_CORE, sram_addr(SRAM_WORDS), rd);
    check_word("core_rdata_o", UNMAPPED_RDATA, rd);
    bus_read(PORT_CORE, 32'h0010_0000, rd);
    check_word("core_rdata_o", UNMAPPED_RDATA, rd);
    bus_read(PORT_CORE, sram_addr(0), rd);
    check_word("core_rdata_o", model_mem[0], rd);
    end_test();
  endtask

  task automatic arbitration_rounds();
    logic [31:0] rd;
    logic [31:0] core_val;
    logic [31:0] ldr_val;
    int          expect_first;
    int          first;
    start_test("arbitration");
    apply_reset();
    for (int r = 0; r < 4; r++) begin
      // a solo core access hands the next tie to the loader
      if (r % 2 == 1) bus_write(PORT_CORE, sram_addr(100), 32'(r), 4'hf);
      expect_first = (last_port == PORT_LDR) ? PORT_CORE : PORT_LDR;
      core_val     = next_random();
      ldr_val      = next_random();
      fork
        bus_write(PORT_CORE, sram_addr(64 + 2 * r), core_val, 4'hf);
        bus_write(PORT_LDR, sram_addr(65 + 2 * r), ldr_val, 4'hf);
      join
      first = (done_time[PORT_CORE] < done_time[PORT_LDR]) ? PORT_CORE : PORT_LDR;
      if (first != expect_first) begin
        $display("round %0d: the %s port finished first, the other port should have won",
                 r, (first == PORT_CORE) ? "core" : "loader");
        errors++;
      end
      bus_read(PORT_CORE, sram_addr(64 + 2 * r), rd);
      check_word("core_rdata_o", core_val, rd);
      bus_read(PORT_LDR, sram_addr(65 + 2 * r), rd);
      check_word("ldr_rdata_o", ldr_val, rd);
    end
    end_test();
  endtask

  task automatic loader_sharing();
    logic [31:0] blk [8];
    logic [31:0] rd;
    logic [31:0] val;
    start_test("loader");
    for (int i = 0; i < 8; i++) begin
      blk[i] = next_random();
      bus_write(PORT_LDR, sram_addr(128 + i), blk[i], 4'hf);
    end
    for (int i = 0; i < 8; i++) begin
      bus_read(PORT_CORE, sram_addr(128 + i), rd);
      check_word("core_rdata_o", blk[i], rd);
    end
    // core asks one cycle into a loader write and has to wait
    val = next_random();
    fork
      bus_write(PORT_LDR, sram_addr(136), val, 4'hf);
      begin
        @(posedge clk);
        bus_read(PORT_CORE, sram_addr(136), rd);
      end
    join
    if (done_time[PORT_CORE] <= done_time[PORT_LDR]) begin
      $display("core request completed while the loader still held the bus");
      errors++;
    end
    check_word("core_rdata_o", val, rd);
    end_test();
  endtask

  task automatic gpio_pins();
    logic [GPIO_WIDTH-1:0] out_val;
    logic [GPIO_WIDTH-1:0] oen_val;
    logic [GPIO_WIDTH-1:0] in_val;
    logic [          31:0] rd;
    start_test("gpio");
    apply_reset();
    @(negedge clk);
    check_gpio("gpio_out_o", '0, gpio_out);
    check_gpio("gpio_oen_o", '0, gpio_oen);
    out_val = GPIO_WIDTH'(next_random());
    oen_val = GPIO_WIDTH'(next_random());
    in_val  = GPIO_WIDTH'(next_random());
    bus_write(PORT_CORE, GPIO_BASE + 32'(GPIO_OUT_OFS), 32'(out_val), 4'hf);
    bus_write(PORT_CORE, GPIO_BASE + 32'(GPIO_OEN_OFS), 32'(oen_val), 4'hf);
    @(negedge clk);
    check_gpio("gpio_out_o", out_val, gpio_out);
    check_gpio("gpio_oen_o", oen_val, gpio_oen);
    bus_read(PORT_CORE, GPIO_BASE + 32'(GPIO_OUT_OFS), rd);
    check_word("core_rdata_o", 32'(out_val), rd);
    bus_read(PORT_CORE, GPIO_BASE + 32'(GPIO_OEN_OFS), rd);
    check_word("core_rdata_o", 32'(oen_val), rd);
    // pins go through two flops before the register
    @(posedge clk);
    gpio_in <= in_val;
    repeat (3) @(posedge clk);
    bus_read(PORT_CORE, GPIO_BASE + 32'(GPIO_IN_OFS), rd);
    check_word("core_rdata_o", 32'(in_val), rd);
    bus_write(PORT_CORE, GPIO_BASE + 32'(GPIO_IN_OFS), ~32'(in_val), 4'hf);
    bus_read(PORT_CORE, GPIO_BASE + 32'(GPIO_IN_OFS), rd);
    check_word("core_rdata_o", 32'(in_val), rd);
    end_test();
  endtask

  task automatic timer_interrupt();
    logic [31:0] rd;
    logic [31:0] prev;
    int          wait_cyc;
    start_test("timer");
    apply_reset();
    @(negedge clk);
    check_bit("irq_o", 1'b0, irq);
    bus_write(PORT_CORE, TIMER_BASE + 32'(TMR_CMP_OFS), 32'd50, 4'hf);
    bus_write(PORT_CORE, TIMER_BASE + 32'(TMR_CTRL_OFS), 32'd1, 4'hf);
    wait_cyc = 0;
    @(negedge clk);
    while (irq !== 1'b1 && wait_cyc < 60) begin
      @(negedge clk);
      wait_cyc++;
    end
    if (irq !== 1'b1) begin
      $display("irq_o did not rise within 60 cycles of enabling the timer");
      errors++;
    end
    // level holds until software clears it
    repeat (20) begin
      @(negedge clk);
      check_bit("irq_o", 1'b1, irq);
    end
    bus_read(PORT_CORE, TIMER_BASE + 32'(TMR_CNT_OFS), prev);
    for (int k = 0; k < 3; k++) begin
      bus_read(PORT_CORE, TIMER_BASE + 32'(TMR_CNT_OFS), rd);
      if (rd <= prev) begin
        $display("timer count read %0d after %0d, it should keep increasing", rd, prev);
        errors++;
      end
      prev = rd;
    end
    bus_write(PORT_CORE, TIMER_BASE + 32'(TMR_STAT_OFS), 32'd1, 4'hf);
    @(negedge clk);
    check_bit("irq_o", 1'b0, irq);
    bus_write(PORT_CORE, TIMER_BASE + 32'(TMR_CTRL_OFS), 32'd1, 4'hf);
    bus_read(PORT_CORE, TIMER_BASE + 32'(TMR_STAT_OFS), rd);
    check_word("core_rdata_o", 32'h0, rd);
    bus_write(PORT_CORE, TIMER_BASE + 32'(TMR_CTRL_OFS), 32'd0, 4'hf);
    end_test();
  endtask

  task automatic read_latency();
    logic [31:0] rd;
    int          lat;
    start_test("latency");
    bus_access(PORT_CORE, sram_addr(5), 32'h0, 4'h0, rd, lat);
    if (lat != 2) begin
      $display("core_ready_o came %0d cycles after core_valid_i rose, expected 2", lat);
      errors++;
    end
    check_word("core_rdata_o", model_mem[5], rd);
    end_test();
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    core_valid   = 1'b0;
    core_addr    = 32'h0;
    core_wdata   = 32'h0;
    core_wstrb   = 4'h0;
    ldr_valid    = 1'b0;
    ldr_addr     = 32'h0;
    ldr_wdata    = 32'h0;
    ldr_wstrb    = 4'h0;
    gpio_in      = '0;
    rng_state    = 32'hd6a484a9;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    cur_test     = "reset";
    apply_reset();
    sram_access();
    arbitration_rounds();
    loader_sharing();
    gpio_pins();
    timer_interrupt();
    read_latency();
    repeat (2) @(posedge clk);
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // each test gets a budget of 2000 cycles
  initial begin
    #(NUM_TESTS * 2000 * CLK_PERIOD);
    $display("watchdog expired, test %s did not finish", cur_test);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* sources.f */
verilog/mmap_pkg.sv
verilog/bus_arbiter.sv
verilog/bus_decoder.sv
verilog/sram_ctrl.sv
verilog/gpio_regs.sv
verilog/timer_irq.sv
verilog/retrosoc_lite.sv
testbench/tb_retrosoc_lite.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_retrosoc_lite
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
